//--- testbench/softermax_golden.txt
// Columns: score lane 0..3, expected output value lane 0..3, expected max (4-bit signed)
// All fields in hex, lane 0 first
10 00 08 f0 80 40 60 20 1
00 00 00 00 80 80 80 80 0
1f 1a 13 11 f8 d0 98 88 1
70 f0 00 80 80 00 01 00 7
f8 e0 f4 c8 c0 40 a0 18 f
80 81 8f 90 40 44 7c 80 9
25 3c 3e 07 54 e0 f0 17 3
7f 7f 00 01 f8 f8 01 01 7
05 12 23 34 15 24 4c a0 3
4a 31 29 1b d0 44 32 1b 4
ff 01 e8 0f 7c 88 30 f8 0
ff ff ff ff f8 f8 f8 f8 f
80 80 80 80 80 80 80 80 8
60 e0 df 50 80 00 00 40 6
0c f9 2d 1e 38 19 e8 78 2
a0 b7 9c c1 20 5c 1c 88 c
44 44 44 44 a0 a0 a0 a0 4
08 f8 78 88 01 00 c0 00 7
33 27 3a 16 98 5c d0 2c 3
f1 ef d0 fa 88 7c 20 d0 f

//--- vlog.f
design/softermax_fmt_pkg.sv
design/softermax_stream_pkg.sv
design/skid_buffer.sv
design/stream_fifo.sv
design/max_tree.sv
design/lpw_pow2.sv
design/softermax_local_window.sv
testbench/softermax_local_window_checker.sv
testbench/tb_softermax_local_window.sv

//--- testbench/tb_softermax_local_window.sv
`timescale 1ns/1ps

module tb_softermax_local_window;

    localparam int num_windows    = 20;
    localparam int line_words     = 2 * softermax_fmt_pkg::parallelism + 1;
    localparam int timeout_cycles = 40 * num_windows + 200;
    localparam int drain_cycles   = 24;

    logic                          clk;
    logic                          rst_n;
    softermax_stream_pkg::window_t in_data;
    logic                          in_valid;
    logic                          in_ready;
    softermax_stream_pkg::result_t out_data;
    logic                          out_valid;
    logic                          out_ready;

    // Scores, expected values and expected maximum of each window
    logic [softermax_fmt_pkg::in_width-1:0] golden_mem [num_windows * line_words];

    logic [31:0] lfsr_state;
    int          error_count   = 0;
    int          timeout_count = 0;
    int          cycle_count   = 0;

    softermax_local_window UUT (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic softermax_stream_pkg::window_t window_at(input int idx);
        softermax_stream_pkg::window_t w;
        for (int i = 0; i < softermax_fmt_pkg::parallelism; i++) begin
            w[i] = golden_mem[idx * line_words + i];
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic score_output(input string phase_name, input int idx);
        int base;
        base = idx * line_words + softermax_fmt_pkg::parallelism;
        for (int i = 0; i < softermax_fmt_pkg::parallelism; i++) begin
            compare_value($sformatf("%s window %0d lane %0d", phase_name, idx, i),
                          golden_mem[base + i], out_data.values[i]);
        end
        compare_value($sformatf("%s window %0d max", phase_name, idx),
                      golden_mem[base + softermax_fmt_pkg::parallelism]
                          [softermax_fmt_pkg::max_width-1:0],
                      $unsigned(out_data.max));
    endtask

    task automatic confirm_golden_loaded();
        int missing;
        missing = 0;
        for (int k = 0; k < num_windows * line_words; k++) begin
            if ($isunknown(golden_mem[k])) begin
                missing++;
            end
        end
        if (missing != 0) begin
            error_count++;
            $display("Golden file is missing %0d of its %0d expected fields",
                     missing, num_windows * line_words);
        end
    endtask

    // Sender and receiver share one process so LFSR draws keep a fixed order
    task automatic run_phase(input logic use_random, input string phase_name);
        int   tx_idx;
        int   rx_idx;
        logic tx_fire;
        logic want_valid;
        logic ready_a;
        logic ready_b;
        tx_idx  = 0;
        rx_idx  = 0;
        tx_fire = 1'b0;
        while (rx_idx < num_windows) begin
            @(negedge clk);
            if (tx_fire) begin
                tx_idx++;
                in_valid = 1'b0;
            end
            if (tx_idx < num_windows && !in_valid) begin
                want_valid = 1'b1;
                if (use_random) begin
                    draw_bit(want_valid);
                end
                if (want_valid) begin
                    in_data  = window_at(tx_idx);
                    in_valid = 1'b1;
                end
            end
            // in_ready is registered, so this predicts the next rising edge
            tx_fire = in_valid && in_ready;

            // Output side ready a quarter of the time under random stalls
            ready_a = 1'b1;
            ready_b = 1'b1;
            if (use_random) begin
                draw_bit(ready_a);
                draw_bit(ready_b);
            end
            out_ready = ready_a && ready_b;
            if (out_valid && out_ready) begin
                score_output(phase_name, rx_idx);
                rx_idx++;
            end
        end

        in_valid  = 1'b0;
        out_ready = 1'b1;
        compare_value({phase_name, " windows sent"}, num_windows, tx_idx);
        repeat (drain_cycles) begin
            @(negedge clk);
            compare_value({phase_name, " extra output"}, 0, out_valid);
        end
    endtask

    task automatic report_counts();
        $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == timeout_cycles) begin
            timeout_count++;
            $display("Timeout: run reached %0d cycles before all windows were checked",
                     timeout_cycles);
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        lfsr_state = 32'h4a7ea431;

        $readmemh("testbench/softermax_golden.txt", golden_mem);
        confirm_golden_loaded();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing may come out before the first window
        repeat (4) begin
            @(negedge clk);
            compare_value("idle out_valid", 0, out_valid);
        end

        run_phase(1'b0, "back_to_back");
        run_phase(1'b1, "random_stall");

        report_counts();
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/softermax_local_window_checker.sv
`timescale 1ns/1ps

module softermax_local_window_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          in_ready,
    input softermax_stream_pkg::result_t out_data,
    input logic                          out_valid,
    input logic                          out_ready
);

    // High when the previous edge already saw reset, so DUT registers are cleared
    logic in_reset_q;
    // Set by the first accepted window
    logic accepted_q;

    always_ff @(posedge clk) begin
        in_reset_q <= !rst_n;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accepted_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            accepted_q <= 1'b1;
        end
    end

    reset_out_valid_low: assert property (
        @(posedge clk) (!rst_n && in_reset_q) |-> !out_valid
    ) else $error("out_valid is high while reset is applied");

    reset_in_ready_low: assert property (
        @(posedge clk) (!rst_n && in_reset_q) |-> !in_ready
    ) else $error("in_ready is high while reset is applied");

    // Held output beat must not change
    output_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("output beat changed or dropped while stalled");

    no_early_output: assert property (
        @(posedge clk) disable iff (!rst_n) !accepted_q |-> !out_valid
    ) else $error("out_valid rose before any window was accepted");

endmodule

bind softermax_local_window softermax_local_window_checker handshake_checker (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

//--- design/softermax_local_window.sv
`timescale 1ns/1ps

module softermax_local_window (
    input  logic                          clk,
    input  logic                          rst_n,
    input  softermax_stream_pkg::window_t in_data,
    input  logic                          in_valid,
    output logic                          in_ready,
    output softermax_stream_pkg::result_t out_data,
    output logic                          out_valid,
    input  logic                          out_ready
);

    softermax_stream_pkg::int_window_t round_in_data;
    softermax_stream_pkg::int_window_t round_out_data;
    logic                              round_in_valid, round_in_ready;
    logic                              round_out_valid, round_out_ready;

    softermax_stream_pkg::window_t     score_out_data;
    logic                              score_in_valid, score_in_ready;
    logic                              score_out_valid, score_out_ready;

    softermax_stream_pkg::max_t        tree_out_data;
    logic                              tree_out_valid, tree_out_ready;

    softermax_stream_pkg::max_t        sub_max_data;
    logic                              sub_max_in_valid, sub_max_in_ready;
    logic                              sub_max_valid, sub_max_ready;

    softermax_stream_pkg::max_t        max_fifo_out_data;
    logic                              max_fifo_in_valid, max_fifo_in_ready;
    logic                              max_fifo_out_valid, max_fifo_out_ready;

    logic                                      join_valid, join_ready;
    logic [softermax_fmt_pkg::parallelism-1:0] diff_in_ready;
    logic [softermax_fmt_pkg::parallelism-1:0] pow_valid;
    logic                                      pow_ready;
    logic [softermax_fmt_pkg::parallelism-1:0][softermax_fmt_pkg::out_width-1:0] pow_data;

    // Input fork waits for both branches
    assign in_ready       = score_in_ready && round_in_ready;
    assign score_in_valid = in_valid && round_in_ready;
    assign round_in_valid = in_valid && score_in_ready;

    stream_fifo #(.payload_t(softermax_stream_pkg::window_t), .depth(softermax_fmt_pkg::fifo_depth))
    score_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_data(in_data), .in_valid(score_in_valid), .in_ready(score_in_ready),
        .out_data(score_out_data), .out_valid(score_out_valid), .out_ready(score_out_ready)
    );

    skid_buffer #(.payload_t(softermax_stream_pkg::int_window_t)) round_buff (
        .clk(clk), .rst_n(rst_n),
        .in_data(round_in_data), .in_valid(round_in_valid), .in_ready(round_in_ready),
        .out_data(round_out_data), .out_valid(round_out_valid), .out_ready(round_out_ready)
    );

    max_tree comparator (
        .clk(clk), .rst_n(rst_n),
        .in_data(round_out_data), .in_valid(round_out_valid), .in_ready(round_out_ready),
        .out_data(tree_out_data), .out_valid(tree_out_valid), .out_ready(tree_out_ready)
    );

    // Maximum goes both to the subtract and to the output
    assign tree_out_ready    = sub_max_in_ready && max_fifo_in_ready;
    assign sub_max_in_valid  = tree_out_valid && max_fifo_in_ready;
    assign max_fifo_in_valid = tree_out_valid && sub_max_in_ready;

    skid_buffer #(.payload_t(softermax_stream_pkg::max_t)) sub_max_buff (
        .clk(clk), .rst_n(rst_n),
        .in_data(tree_out_data), .in_valid(sub_max_in_valid), .in_ready(sub_max_in_ready),
        .out_data(sub_max_data), .out_valid(sub_max_valid), .out_ready(sub_max_ready)
    );

    stream_fifo #(.payload_t(softermax_stream_pkg::max_t), .depth(softermax_fmt_pkg::max_fifo_depth))
    max_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_data(tree_out_data), .in_valid(max_fifo_in_valid), .in_ready(max_fifo_in_ready),
        .out_data(max_fifo_out_data), .out_valid(max_fifo_out_valid),
        .out_ready(max_fifo_out_ready)
    );

    // Scores meet their maximum
    assign join_valid      = sub_max_valid && score_out_valid;
    assign join_ready      = &diff_in_ready;
    assign sub_max_ready   = score_out_valid && join_ready;
    assign score_out_ready = sub_max_valid && join_ready;

    for (genvar i = 0; i < softermax_fmt_pkg::parallelism; i++) begin : lane
        softermax_stream_pkg::diff_t diff_in_data;
        softermax_stream_pkg::diff_t diff_out_data;
        logic                        diff_out_valid, diff_out_ready;

        // Floor rounding by dropping the fraction bits
        assign round_in_data[i] =
            in_data[i][softermax_fmt_pkg::in_width-1:softermax_fmt_pkg::in_frac_width];

        assign diff_in_data = softermax_stream_pkg::diff_t'(score_out_data[i])
            - (softermax_stream_pkg::diff_t'(sub_max_data) <<< softermax_fmt_pkg::in_frac_width);

        skid_buffer #(.payload_t(softermax_stream_pkg::diff_t)) diff_reg (
            .clk(clk), .rst_n(rst_n),
            .in_data(diff_in_data), .in_valid(join_valid && join_ready),
            .in_ready(diff_in_ready[i]),
            .out_data(diff_out_data), .out_valid(diff_out_valid), .out_ready(diff_out_ready)
        );

        lpw_pow2 pow2 (
            .clk(clk), .rst_n(rst_n),
            .in_data(diff_out_data), .in_valid(diff_out_valid), .in_ready(diff_out_ready),
            .out_data(pow_data[i]), .out_valid(pow_valid[i]), .out_ready(pow_ready)
        );
    end

    // All lanes and the maximum leave together
    assign out_valid          = (&pow_valid) && max_fifo_out_valid;
    assign pow_ready          = out_ready && out_valid;
    assign max_fifo_out_ready = out_ready && (&pow_valid);

    assign out_data.values = pow_data;
    assign out_data.max    = max_fifo_out_data;

endmodule

//--- design/lpw_pow2.sv
`timescale 1ns/1ps

module lpw_pow2 (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic signed [softermax_fmt_pkg::sub_width-1:0] in_data,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    output logic        [softermax_fmt_pkg::out_width-1:0] out_data,
    output logic                                           out_valid,
    input  logic                                           out_ready
);

    logic signed [softermax_fmt_pkg::sub_int_width-1:0] int_part;
    logic        [softermax_fmt_pkg::in_frac_width-1:0] frac_part;
    logic        [softermax_fmt_pkg::sub_int_width-1:0] shift;
    logic        [softermax_fmt_pkg::out_width-1:0]     mantissa;
    logic        [softermax_fmt_pkg::out_width-1:0]     pow_value;
    logic        [softermax_fmt_pkg::out_width-1:0]     result_q;
    logic                                               valid_q;

    assign int_part  = in_data[softermax_fmt_pkg::sub_width-1:softermax_fmt_pkg::in_frac_width];
    assign frac_part = in_data[softermax_fmt_pkg::in_frac_width-1:0];

    // Negated integer part gives the right shift
    assign shift = -int_part;

    // 1 + frac aligned to the output binary point
    assign mantissa = {1'b1, frac_part,
                       {(softermax_fmt_pkg::out_frac_width - softermax_fmt_pkg::in_frac_width){1'b0}}};

    assign pow_value = (shift >= softermax_fmt_pkg::out_width) ? '0 : (mantissa >> shift);

    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = result_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            result_q <= pow_value;
        end
    end

endmodule

//--- design/max_tree.sv
`timescale 1ns/1ps

module max_tree (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  softermax_stream_pkg::int_window_t              in_data,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    output logic signed [softermax_fmt_pkg::max_width-1:0] out_data,
    output logic                                           out_valid,
    input  logic                                           out_ready
);

    // Level l holds parallelism >> l partial maxima
    softermax_stream_pkg::max_t node_q [1:softermax_fmt_pkg::tree_depth]
                                       [softermax_fmt_pkg::parallelism/2];
    logic [softermax_fmt_pkg::tree_depth:1] valid_q;
    logic                                   advance;

    function automatic softermax_stream_pkg::max_t smax(
        input softermax_stream_pkg::max_t a,
        input softermax_stream_pkg::max_t b
    );
        return (a > b) ? a : b;
    endfunction

    // Whole tree moves in lockstep
    assign advance   = !valid_q[softermax_fmt_pkg::tree_depth] || out_ready;
    assign in_ready  = advance;
    assign out_valid = valid_q[softermax_fmt_pkg::tree_depth];
    assign out_data  = node_q[softermax_fmt_pkg::tree_depth][0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[1] <= in_valid;
            for (int l = 2; l <= softermax_fmt_pkg::tree_depth; l++) begin
                valid_q[l] <= valid_q[l-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // First level compares input pairs
            for (int i = 0; i < softermax_fmt_pkg::parallelism / 2; i++) begin
                node_q[1][i] <= smax(in_data[2*i], in_data[2*i+1]);
            end
            for (int l = 2; l <= softermax_fmt_pkg::tree_depth; l++) begin
                for (int i = 0; i < (softermax_fmt_pkg::parallelism >> l); i++) begin
                    node_q[l][i] <= smax(node_q[l-1][2*i], node_q[l-1][2*i+1]);
                end
            end
        end
    end

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;

    payload_t                   mem [depth];
    logic [addr_width-1:0]      wr_ptr;
    logic [addr_width-1:0]      rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_write;
    logic                       do_read;

    // Pointer wrap also works for depths that are not a power of two
    function automatic logic [addr_width-1:0] next_ptr(input logic [addr_width-1:0] ptr);
        if (ptr == addr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count < depth);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

//--- design/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_q;
    payload_t spare_q;
    logic     main_valid;
    logic     spare_valid;
    logic     ready_q;
    logic     main_load;

    // Main register takes a beat when empty or being read
    assign main_load = !main_valid || out_ready;

    assign in_ready  = ready_q;
    assign out_data  = main_q;
    assign out_valid = main_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            ready_q     <= 1'b0;
        end else if (main_load) begin
            main_valid  <= spare_valid || (in_valid && ready_q);
            spare_valid <= 1'b0;
            ready_q     <= 1'b1;
        end else if (in_valid && ready_q) begin
            // Beat parks in the spare slot while the output stalls
            spare_valid <= 1'b1;
            ready_q     <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_q <= spare_valid ? spare_q : in_data;
        end
        if (!main_load && ready_q) begin
            spare_q <= in_data;
        end
    end

endmodule

//--- design/softermax_stream_pkg.sv
package softermax_stream_pkg;

    // Single lane words
    typedef logic signed [softermax_fmt_pkg::in_width-1:0]  score_t;
    typedef logic signed [softermax_fmt_pkg::max_width-1:0] max_t;
    typedef logic signed [softermax_fmt_pkg::sub_width-1:0] diff_t;

    // One input beat of raw scores
    typedef score_t [softermax_fmt_pkg::parallelism-1:0] window_t;

    // Floor-rounded scores feeding the comparator tree
    typedef max_t [softermax_fmt_pkg::parallelism-1:0] int_window_t;

    // Output beat with the power-of-two values and the local maximum
    typedef struct packed {
        logic [softermax_fmt_pkg::parallelism-1:0][softermax_fmt_pkg::out_width-1:0] values;
        max_t                                                                      max;
    } result_t;

endpackage

//--- design/softermax_fmt_pkg.sv
package softermax_fmt_pkg;

    // Scores per local window
    localparam int parallelism = 4;

    // Signed fixed-point input scores
    localparam int in_width      = 8;
    localparam int in_frac_width = 4;

    // Integer part left after floor rounding
    localparam int max_width = in_width - in_frac_width;

    // One extra bit covers score minus scaled maximum
    localparam int sub_width     = in_width + 1;
    localparam int sub_int_width = sub_width - in_frac_width;

    // Unsigned output where 1.0 maps to 128
    localparam int out_width      = 8;
    localparam int out_frac_width = 7;

    // Comparator tree levels
    localparam int tree_depth = $clog2(parallelism);

    // Buffer depths
    localparam int fifo_depth     = 16;
    localparam int max_fifo_depth = 8;

endpackage
